// ==== tb.f ====
+incdir+common
common/regmap_pkg.sv
common/lane_pkg.sv
common/free_list_if.sv
rename/map_table.sv
rename/free_list.sv
hdl/rename_top.sv
verification/rename_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module rename_tb

out=$(./obj_dir/Vrename_tb)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1

// ==== verification/rename_tb.sv ====
`include "rename_params.svh"

module rename_tb;
    import regmap_pkg::*;
    import lane_pkg::*;

    // Expected length of all tests in cycles and the watchdog slack
    localparam int TEST_CYCLES = 260;
    localparam int MARGIN      = 40;

    logic       clk;
    logic       reset;
    logic       flush;
    lane_mask_t dv;
    lane_mask_t we;
    lane_mask_t cv;
    arch_reg_t  rs1_a  [`RN_LANES];
    arch_reg_t  rs2_a  [`RN_LANES];
    arch_reg_t  rd_a   [`RN_LANES];
    arch_reg_t  c_arch [`RN_LANES];
    rob_idx_t   c_idx  [`RN_LANES];
    phys_tag_t  rs1_p  [`RN_LANES];
    phys_tag_t  rs2_p  [`RN_LANES];
    phys_tag_t  rd_p   [`RN_LANES];
    phys_tag_t  old_p  [`RN_LANES];
    lane_mask_t valid_o;
    lane_mask_t ready_o;

    // Reference map and free-list queue
    phys_tag_t  m_map  [`RN_ARCH_REGS];
    rob_idx_t   m_free [$];

    // Allocations not yet committed, used by the random test
    arch_reg_t  fly_arch [$];
    rob_idx_t   fly_idx  [$];

    int errors;
    int seed;

    rename_top dut0 (
        .clk (clk), .reset (reset), .flush_i (flush), .decode_valid_i (dv),
        .rs1_arch_0_i (rs1_a[0]), .rs1_arch_1_i (rs1_a[1]), .rs1_arch_2_i (rs1_a[2]),
        .rs2_arch_0_i (rs2_a[0]), .rs2_arch_1_i (rs2_a[1]), .rs2_arch_2_i (rs2_a[2]),
        .rd_arch_0_i (rd_a[0]), .rd_arch_1_i (rd_a[1]), .rd_arch_2_i (rd_a[2]),
        .rd_we_i (we), .commit_valid_i (cv),
        .commit_arch_0_i (c_arch[0]), .commit_arch_1_i (c_arch[1]),
        .commit_arch_2_i (c_arch[2]),
        .commit_idx_0_i (c_idx[0]), .commit_idx_1_i (c_idx[1]), .commit_idx_2_i (c_idx[2]),
        .rs1_phys_0_o (rs1_p[0]), .rs1_phys_1_o (rs1_p[1]), .rs1_phys_2_o (rs1_p[2]),
        .rs2_phys_0_o (rs2_p[0]), .rs2_phys_1_o (rs2_p[1]), .rs2_phys_2_o (rs2_p[2]),
        .rd_phys_0_o (rd_p[0]), .rd_phys_1_o (rd_p[1]), .rd_phys_2_o (rd_p[2]),
        .old_rd_phys_0_o (old_p[0]), .old_rd_phys_1_o (old_p[1]),
        .old_rd_phys_2_o (old_p[2]),
        .rename_valid_o (valid_o), .rename_ready_o (ready_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ========================================
    // Compare tasks and model
    // ========================================

    task automatic check_tag(string name, phys_tag_t got, phys_tag_t exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_mask(string name, lane_mask_t got, lane_mask_t exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Identity map and a full ring in order
    task automatic reset_model();
        m_free.delete();
        for (int r = 0; r < `RN_ARCH_REGS; r++) begin
            m_map[r] = phys_tag_t'(r);
            m_free.push_back(rob_idx_t'(r));
        end
    endtask

    task automatic clear_inputs();
        flush = 1'b0;
        dv    = '0;
        we    = '0;
        cv    = '0;
        for (int k = 0; k < `RN_LANES; k++) begin
            rs1_a[k]  = '0;
            rs2_a[k]  = '0;
            rd_a[k]   = '0;
            c_arch[k] = '0;
            c_idx[k]  = '0;
        end
    endtask

    // Wait for the falling edge and return the inputs to idle
    task automatic wait_fall();
        @(negedge clk);
        clear_inputs();
    endtask

    // Compare this cycle's outputs with the model and step the model
    task automatic compare_and_step();
        lane_mask_t e_ready;
        lane_mask_t e_go;
        lane_mask_t e_fwd;
        phys_tag_t  e_new [`RN_LANES];
        phys_tag_t  e_rs1;
        phys_tag_t  e_rs2;
        int         cnt;
        // Outputs settle well before the rising edge
        #20;
        cnt = m_free.size();
        e_ready = (cnt >= 3) ? 3'b111 : (cnt == 2) ? 3'b011 : (cnt == 1) ? 3'b001 : 3'b000;
        e_go = dv & e_ready;
        for (int k = 0; k < `RN_LANES; k++) begin
            e_new[k] = e_go[k] ? {1'b1, m_free[k]} : '0;
            e_fwd[k] = e_go[k] && we[k] && (rd_a[k] != '0);
        end
        check_mask("rename_ready_o", ready_o, e_ready);
        check_mask("rename_valid_o", valid_o, e_go);
        for (int j = 0; j < `RN_LANES; j++) begin
            e_rs1 = m_map[rs1_a[j]];
            e_rs2 = m_map[rs2_a[j]];
            // Scan older lanes upward so the nearest writer wins
            for (int i = 0; i < j; i++) begin
                if (e_fwd[i] && rd_a[i] == rs1_a[j]) begin
                    e_rs1 = e_new[i];
                end
                if (e_fwd[i] && rd_a[i] == rs2_a[j]) begin
                    e_rs2 = e_new[i];
                end
            end
            check_tag($sformatf("rs1_phys_%0d_o", j), rs1_p[j], e_rs1);
            check_tag($sformatf("rs2_phys_%0d_o", j), rs2_p[j], e_rs2);
            check_tag($sformatf("rd_phys_%0d_o", j), rd_p[j], e_new[j]);
            check_tag($sformatf("old_rd_phys_%0d_o", j), old_p[j],
                      e_go[j] ? m_map[rd_a[j]] : '0);
        end
        if (flush) begin
            reset_model();
        end else begin
            // Commits first and only where the map still names the slot
            for (int k = 0; k < `RN_LANES; k++) begin
                if (cv[k] && c_arch[k] != '0 && m_map[c_arch[k]] == {1'b1, c_idx[k]}) begin
                    m_map[c_arch[k]] = {1'b0, c_arch[k]};
                end
            end
            for (int k = 0; k < `RN_LANES; k++) begin
                if (e_fwd[k]) begin
                    m_map[rd_a[k]] = e_new[k];
                end
            end
            for (int k = 0; k < `RN_LANES; k++) begin
                if (e_go[k]) begin
                    void'(m_free.pop_front());
                end
            end
            for (int k = 0; k < `RN_LANES; k++) begin
                if (cv[k]) begin
                    m_free.push_back(c_idx[k]);
                end
            end
        end
    endtask

    // ========================================
    // Directed tests
    // ========================================

    task automatic identity_after_reset();
        for (int c = 0; c < 11; c++) begin
            wait_fall();
            for (int k = 0; k < `RN_LANES; k++) begin
                rs1_a[k] = arch_reg_t'(3 * c + k);
                rs2_a[k] = arch_reg_t'(31 - 3 * c - k);
            end
            compare_and_step();
            for (int k = 0; k < `RN_LANES; k++) begin
                check_tag("rs1_phys identity", rs1_p[k], {1'b0, rs1_a[k]});
            end
            check_mask("rename_ready_o after reset", ready_o, 3'b111);
        end
    endtask

    task automatic three_lane_rename();
        wait_fall();
        dv = 3'b111;
        we = 3'b111;
        rd_a[0] = 5'd1;
        rd_a[1] = 5'd2;
        rd_a[2] = 5'd3;
        compare_and_step();
        check_tag("rd_phys_0_o", rd_p[0], 6'd32);
        check_tag("rd_phys_2_o", rd_p[2], 6'd34);
        check_tag("old_rd_phys_1_o", old_p[1], 6'd2);
        // New mappings visible one cycle later
        wait_fall();
        rs1_a[0] = 5'd1;
        rs1_a[1] = 5'd2;
        rs2_a[2] = 5'd3;
        compare_and_step();
        check_tag("rs2_phys_2_o", rs2_p[2], 6'd34);
    endtask

    task automatic group_bypass();
        wait_fall();
        dv = 3'b111;
        we = 3'b111;
        rd_a[0]  = 5'd5;
        rd_a[1]  = 5'd6;
        rd_a[2]  = 5'd9;
        rs1_a[1] = 5'd5;
        rs1_a[2] = 5'd5;
        rs2_a[2] = 5'd6;
        compare_and_step();
        check_tag("rs1_phys_2_o", rs1_p[2], 6'd35);
        check_tag("rs2_phys_2_o", rs2_p[2], 6'd36);
        // x0 and a lane without write enable must not forward
        wait_fall();
        dv = 3'b111;
        we = 3'b101;
        rd_a[1]  = 5'd7;
        rd_a[2]  = 5'd8;
        rs1_a[1] = 5'd0;
        rs1_a[2] = 5'd7;
        compare_and_step();
        check_tag("rs1_phys_1_o", rs1_p[1], 6'd0);
        check_tag("rs1_phys_2_o", rs1_p[2], 6'd7);
        // Two older writers of one register
        wait_fall();
        dv = 3'b111;
        we = 3'b111;
        rd_a[0]  = 5'd10;
        rd_a[1]  = 5'd10;
        rs1_a[2] = 5'd10;
        rs2_a[1] = 5'd10;
        compare_and_step();
        check_tag("rs1_phys_2_o", rs1_p[2], 6'd42);
        check_tag("rs2_phys_1_o", rs2_p[1], 6'd41);
    endtask

    task automatic credit_backpressure();
        wait_fall();
        flush = 1'b1;
        compare_and_step();
        // Allocation n writes register n mod 15 plus 1
        for (int c = 0; c < 11; c++) begin
            wait_fall();
            dv = (c < 10) ? 3'b111 : 3'b011;
            we = 3'b111;
            for (int k = 0; k < `RN_LANES; k++) begin
                rd_a[k] = arch_reg_t'((3 * c + k) % 15 + 1);
            end
            compare_and_step();
            if (c == 10) begin
                check_mask("rename_ready_o after 30", ready_o, 3'b011);
            end
        end
        // Register 3 last took index 17 and its commit of index 2 is stale
        wait_fall();
        cv = 3'b111;
        c_arch[0] = 5'd1;
        c_idx[0]  = 5'd30;
        c_arch[1] = 5'd2;
        c_idx[1]  = 5'd31;
        c_arch[2] = 5'd3;
        c_idx[2]  = 5'd2;
        compare_and_step();
        check_mask("rename_ready_o after 32", ready_o, 3'b000);
        wait_fall();
        rs1_a[0] = 5'd1;
        rs1_a[1] = 5'd2;
        rs1_a[2] = 5'd3;
        compare_and_step();
        check_mask("rename_ready_o after commit", ready_o, 3'b111);
        check_tag("rs1_phys_0_o", rs1_p[0], 6'd1);
        check_tag("rs1_phys_2_o", rs1_p[2], 6'd49);
    endtask

    task automatic flush_recovery();
        wait_fall();
        dv = 3'b111;
        we = 3'b111;
        rd_a[0] = 5'd4;
        rd_a[1] = 5'd5;
        rd_a[2] = 5'd6;
        compare_and_step();
        wait_fall();
        flush = 1'b1;
        compare_and_step();
        wait_fall();
        rs1_a[0] = 5'd4;
        rs1_a[1] = 5'd5;
        rs1_a[2] = 5'd6;
        compare_and_step();
        check_tag("rs1_phys_1_o after flush", rs1_p[1], 6'd5);
        check_mask("rename_ready_o after flush", ready_o, 3'b111);
        wait_fall();
        dv = 3'b111;
        we = 3'b111;
        rd_a[0] = 5'd7;
        compare_and_step();
        check_tag("rd_phys_0_o after flush", rd_p[0], 6'd32);
    endtask

    task automatic random_traffic();
        int       n_free;
        int       n_lanes;
        int       n_commit;
        bit [31:0] r;
        rob_idx_t new_idx [`RN_LANES];
        wait_fall();
        flush = 1'b1;
        compare_and_step();
        fly_arch.delete();
        fly_idx.delete();
        for (int c = 0; c < 200; c++) begin
            wait_fall();
            n_free = (m_free.size() > 3) ? 3 : m_free.size();
            n_lanes = ($random(seed) & 32'h7fff_ffff) % (n_free + 1);
            dv = lane_mask_t'((1 << n_lanes) - 1);
            for (int k = 0; k < `RN_LANES; k++) begin
                r = $random(seed);
                rs1_a[k] = arch_reg_t'(r[4:0]);
                rs2_a[k] = arch_reg_t'(r[9:5]);
                // Small register range makes bypass hits likely
                rd_a[k]  = arch_reg_t'(r[12:10]);
                we[k]    = r[16];
                new_idx[k] = (k < n_lanes) ? m_free[k] : '0;
            end
            n_commit = (fly_idx.size() > 3) ? 3 : fly_idx.size();
            n_commit = ($random(seed) & 32'h7fff_ffff) % (n_commit + 1);
            cv = lane_mask_t'((1 << n_commit) - 1);
            for (int k = 0; k < n_commit; k++) begin
                c_arch[k] = fly_arch.pop_front();
                c_idx[k]  = fly_idx.pop_front();
            end
            compare_and_step();
            for (int k = 0; k < n_lanes; k++) begin
                fly_arch.push_back(rd_a[k]);
                fly_idx.push_back(new_idx[k]);
            end
        end
    endtask

    // ========================================
    // Main sequence and watchdog
    // ========================================

    initial begin
        errors = 0;
        seed   = 91;
        reset  = 1'b0;
        clear_inputs();
        reset_model();
        repeat (16) @(negedge clk);
        reset = 1'b1;
        identity_after_reset();
        three_lane_rename();
        group_bypass();
        credit_backpressure();
        flush_recovery();
        random_traffic();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #((TEST_CYCLES + MARGIN) * 100);
        $display("Watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

endmodule

// ==== hdl/rename_top.sv ====
`include "rename_params.svh"

module rename_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush_i,
    // Decode
    input  lane_pkg::lane_mask_t  decode_valid_i,
    input  regmap_pkg::arch_reg_t rs1_arch_0_i,
    input  regmap_pkg::arch_reg_t rs1_arch_1_i,
    input  regmap_pkg::arch_reg_t rs1_arch_2_i,
    input  regmap_pkg::arch_reg_t rs2_arch_0_i,
    input  regmap_pkg::arch_reg_t rs2_arch_1_i,
    input  regmap_pkg::arch_reg_t rs2_arch_2_i,
    input  regmap_pkg::arch_reg_t rd_arch_0_i,
    input  regmap_pkg::arch_reg_t rd_arch_1_i,
    input  regmap_pkg::arch_reg_t rd_arch_2_i,
    input  lane_pkg::lane_mask_t  rd_we_i,
    // Commit
    input  lane_pkg::lane_mask_t  commit_valid_i,
    input  regmap_pkg::arch_reg_t commit_arch_0_i,
    input  regmap_pkg::arch_reg_t commit_arch_1_i,
    input  regmap_pkg::arch_reg_t commit_arch_2_i,
    input  regmap_pkg::rob_idx_t  commit_idx_0_i,
    input  regmap_pkg::rob_idx_t  commit_idx_1_i,
    input  regmap_pkg::rob_idx_t  commit_idx_2_i,
    // Rename results
    output regmap_pkg::phys_tag_t rs1_phys_0_o,
    output regmap_pkg::phys_tag_t rs1_phys_1_o,
    output regmap_pkg::phys_tag_t rs1_phys_2_o,
    output regmap_pkg::phys_tag_t rs2_phys_0_o,
    output regmap_pkg::phys_tag_t rs2_phys_1_o,
    output regmap_pkg::phys_tag_t rs2_phys_2_o,
    output regmap_pkg::phys_tag_t rd_phys_0_o,
    output regmap_pkg::phys_tag_t rd_phys_1_o,
    output regmap_pkg::phys_tag_t rd_phys_2_o,
    output regmap_pkg::phys_tag_t old_rd_phys_0_o,
    output regmap_pkg::phys_tag_t old_rd_phys_1_o,
    output regmap_pkg::phys_tag_t old_rd_phys_2_o,
    output lane_pkg::lane_mask_t  rename_valid_o,
    output lane_pkg::lane_mask_t  rename_ready_o
);
    import regmap_pkg::*;

    // Lane-packed results, lane 0 in the low slot
    phys_tag_t [`RN_LANES-1:0] rs1_phys;
    phys_tag_t [`RN_LANES-1:0] rs2_phys;
    phys_tag_t [`RN_LANES-1:0] rd_phys;
    phys_tag_t [`RN_LANES-1:0] old_rd_phys;

    // Allocation and release path
    free_list_if fl_if ();

    map_table map0 (
        .clk            (clk),
        .reset          (reset),
        .flush_i        (flush_i),
        .decode_valid_i (decode_valid_i),
        .rs1_arch_i     ({rs1_arch_2_i, rs1_arch_1_i, rs1_arch_0_i}),
        .rs2_arch_i     ({rs2_arch_2_i, rs2_arch_1_i, rs2_arch_0_i}),
        .rd_arch_i      ({rd_arch_2_i, rd_arch_1_i, rd_arch_0_i}),
        .rd_we_i        (rd_we_i),
        .commit_valid_i (commit_valid_i),
        .commit_arch_i  ({commit_arch_2_i, commit_arch_1_i, commit_arch_0_i}),
        .commit_idx_i   ({commit_idx_2_i, commit_idx_1_i, commit_idx_0_i}),
        .rs1_phys_o     (rs1_phys),
        .rs2_phys_o     (rs2_phys),
        .rd_phys_o      (rd_phys),
        .old_rd_phys_o  (old_rd_phys),
        .rename_valid_o (rename_valid_o),
        .fl             (fl_if.table_side)
    );

    free_list fl0 (
        .clk     (clk),
        .reset   (reset),
        .flush_i (flush_i),
        .fl      (fl_if.list_side)
    );

    // Unpack lanes onto the flat ports
    assign {rs1_phys_2_o, rs1_phys_1_o, rs1_phys_0_o}          = rs1_phys;
    assign {rs2_phys_2_o, rs2_phys_1_o, rs2_phys_0_o}          = rs2_phys;
    assign {rd_phys_2_o, rd_phys_1_o, rd_phys_0_o}             = rd_phys;
    assign {old_rd_phys_2_o, old_rd_phys_1_o, old_rd_phys_0_o} = old_rd_phys;

    // Decode sees the free-list credit directly
    assign rename_ready_o = fl_if.credit;

endmodule

// ==== rename/free_list.sv ====
`include "rename_params.svh"

module free_list (
    input  logic            clk,
    input  logic            reset,
    input  logic            flush_i,
    free_list_if.list_side  fl
);
    import regmap_pkg::*;
    import lane_pkg::*;

    // Ring storage, head reads and tail writes
    rob_idx_t  ring_q [`RN_FL_DEPTH];
    rob_idx_t  head_q;
    rob_idx_t  tail_q;
    fl_count_t count_q;

    // Per-cycle movement
    fl_count_t alloc_num;
    fl_count_t rel_num;
    // Tail slot for each releasing lane
    rob_idx_t [`RN_LANES-1:0] rel_ptr;

    // ========================================
    // Head view and credit
    // ========================================

    always_comb begin
        for (int k = 0; k < `RN_LANES; k++) begin
            // Lane k always takes head plus k
            fl.alloc_idx[k] = ring_q[head_q + rob_idx_t'(k)];
            // Thermometer, bit k set while more than k entries are free
            fl.credit[k]    = (count_q > fl_count_t'(k));
        end
    end

    // Counts and packed release positions
    always_comb begin
        alloc_num = '0;
        rel_num   = '0;
        for (int k = 0; k < `RN_LANES; k++) begin
            rel_ptr[k] = tail_q + rob_idx_t'(rel_num);
            if (fl.alloc_en[k]) begin
                alloc_num = alloc_num + fl_count_t'(1);
            end
            if (fl.release_en[k]) begin
                rel_num = rel_num + fl_count_t'(1);
            end
        end
    end

    // ========================================
    // Ring update
    // ========================================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            // Full ring holding 0 to 31 in order
            for (int i = 0; i < `RN_FL_DEPTH; i++) begin
                ring_q[i] <= rob_idx_t'(i);
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= fl_count_t'(`RN_FL_DEPTH);
        end else if (flush_i) begin
            // Flush drops everything in flight
            for (int i = 0; i < `RN_FL_DEPTH; i++) begin
                ring_q[i] <= rob_idx_t'(i);
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= fl_count_t'(`RN_FL_DEPTH);
        end else begin
            // Releases land at the tail in lane order
            for (int k = 0; k < `RN_LANES; k++) begin
                if (fl.release_en[k]) begin
                    ring_q[rel_ptr[k]] <= fl.release_idx[k];
                end
            end
            head_q  <= head_q + rob_idx_t'(alloc_num);
            tail_q  <= tail_q + rob_idx_t'(rel_num);
            count_q <= count_q - alloc_num + rel_num;
        end
    end

    // Occupancy stays within 0 and the depth across every update
    a_count_range: assert property (@(posedge clk) disable iff (!reset)
        !flush_i |-> (int'(count_q) - int'(alloc_num) + int'(rel_num))
                     inside {[0:`RN_FL_DEPTH]});

endmodule

// ==== rename/map_table.sv ====
`include "rename_params.svh"

module map_table (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  flush_i,
    // Decode group
    input  lane_pkg::lane_mask_t                  decode_valid_i,
    input  regmap_pkg::arch_reg_t [`RN_LANES-1:0] rs1_arch_i,
    input  regmap_pkg::arch_reg_t [`RN_LANES-1:0] rs2_arch_i,
    input  regmap_pkg::arch_reg_t [`RN_LANES-1:0] rd_arch_i,
    input  lane_pkg::lane_mask_t                  rd_we_i,
    // Commit group from the reorder buffer
    input  lane_pkg::lane_mask_t                  commit_valid_i,
    input  regmap_pkg::arch_reg_t [`RN_LANES-1:0] commit_arch_i,
    input  regmap_pkg::rob_idx_t  [`RN_LANES-1:0] commit_idx_i,
    // Rename results
    output regmap_pkg::phys_tag_t [`RN_LANES-1:0] rs1_phys_o,
    output regmap_pkg::phys_tag_t [`RN_LANES-1:0] rs2_phys_o,
    output regmap_pkg::phys_tag_t [`RN_LANES-1:0] rd_phys_o,
    output regmap_pkg::phys_tag_t [`RN_LANES-1:0] old_rd_phys_o,
    output lane_pkg::lane_mask_t                  rename_valid_o,
    // Free list
    free_list_if.table_side                       fl
);
    import regmap_pkg::*;
    import lane_pkg::*;

    // Stored map and the value it takes at the next edge
    phys_tag_t map_q    [`RN_ARCH_REGS];
    phys_tag_t map_next [`RN_ARCH_REGS];

    // Lanes that actually rename this cycle
    lane_mask_t lane_go;
    // Lanes whose destination updates the map and feeds younger lanes
    lane_mask_t fwd_en;
    // Fresh reorder-buffer tag per lane, zero when idle
    phys_tag_t [`RN_LANES-1:0] new_tag;

    // ========================================
    // Lane qualification and allocation
    // ========================================

    // Only lanes with credit may take an index
    assign lane_go        = decode_valid_i & fl.credit;
    assign fl.alloc_en    = lane_go;
    assign rename_valid_o = lane_go;

    // Commits hand their slot back to the ring
    assign fl.release_en  = commit_valid_i;
    assign fl.release_idx = commit_idx_i;

    always_comb begin
        for (int k = 0; k < `RN_LANES; k++) begin
            // x0 and lanes without a write never change the map
            fwd_en[k]  = lane_go[k] && rd_we_i[k] && (rd_arch_i[k] != '0);
            new_tag[k] = lane_go[k] ? phys_tag_t'({1'b1, fl.alloc_idx[k]}) : '0;
        end
    end

    // ========================================
    // Lookup with same-group bypass
    // ========================================

    always_comb begin
        for (int j = 0; j < `RN_LANES; j++) begin
            rs1_phys_o[j] = map_q[rs1_arch_i[j]];
            rs2_phys_o[j] = map_q[rs2_arch_i[j]];
            // Scan older lanes upward so the nearest one wins
            for (int i = 0; i < `RN_LANES; i++) begin
                if (i < j && fwd_en[i] && rd_arch_i[i] == rs1_arch_i[j]) begin
                    rs1_phys_o[j] = new_tag[i];
                end
                if (i < j && fwd_en[i] && rd_arch_i[i] == rs2_arch_i[j]) begin
                    rs2_phys_o[j] = new_tag[i];
                end
            end
            // Destination side
            rd_phys_o[j]     = new_tag[j];
            old_rd_phys_o[j] = lane_go[j] ? map_q[rd_arch_i[j]] : '0;
        end
    end

    // ========================================
    // Next map, commits first then renames
    // ========================================

    always_comb begin
        map_next = map_q;
        // Revert to the register file only if the map still names this slot
        for (int k = 0; k < `RN_LANES; k++) begin
            if (commit_valid_i[k] && commit_arch_i[k] != '0 &&
                map_next[commit_arch_i[k]] == phys_tag_t'({1'b1, commit_idx_i[k]})) begin
                map_next[commit_arch_i[k]] = phys_tag_t'({1'b0, commit_arch_i[k]});
            end
        end
        // Newest lane is applied last and wins
        for (int k = 0; k < `RN_LANES; k++) begin
            if (fwd_en[k]) begin
                map_next[rd_arch_i[k]] = new_tag[k];
            end
        end
    end

    // Identity map on reset and flush
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int r = 0; r < `RN_ARCH_REGS; r++) begin
                map_q[r] <= phys_tag_t'(r);
            end
        end else if (flush_i) begin
            for (int r = 0; r < `RN_ARCH_REGS; r++) begin
                map_q[r] <= phys_tag_t'(r);
            end
        end else begin
            map_q <= map_next;
        end
    end

    // ========================================
    // Checks
    // ========================================

    // x0 is hardwired to tag 0
    a_x0_zero: assert property (@(posedge clk) disable iff (!reset)
        map_q[0] == '0);

    // Decode fills lanes from lane 0 without gaps
    a_valid_contig: assert property (@(posedge clk) disable iff (!reset)
        decode_valid_i inside {3'b000, 3'b001, 3'b011, 3'b111});

    // Decode never outruns the free list
    a_valid_credit: assert property (@(posedge clk) disable iff (!reset)
        (decode_valid_i & ~fl.credit) == '0);

endmodule

// ==== common/free_list_if.sv ====
`include "rename_params.svh"

// ========================================
// Map table to free list link
// ========================================

interface free_list_if;
    import regmap_pkg::*;
    import lane_pkg::*;

    // Lanes taking an index this cycle, contiguous from lane 0
    lane_mask_t                     alloc_en;
    // Entries at head, head+1, head+2
    rob_idx_t [`RN_LANES-1:0]       alloc_idx;
    // Thermometer of free entries
    lane_mask_t                     credit;

    // Committed indices going back to the ring
    lane_mask_t                     release_en;
    rob_idx_t [`RN_LANES-1:0]       release_idx;

    // Rename side requests and returns indices
    modport table_side (
        output alloc_en,
        output release_en,
        output release_idx,
        input  alloc_idx,
        input  credit
    );

    // Ring side supplies indices and credit
    modport list_side (
        input  alloc_en,
        input  release_en,
        input  release_idx,
        output alloc_idx,
        output credit
    );

endinterface

// ==== common/lane_pkg.sv ====
`include "rename_params.svh"

// ========================================
// Per-lane control types
// ========================================

package lane_pkg;

    // One bit per rename lane, bit 0 is the oldest lane
    // Used for decode valid, write enables, commits and credit
    typedef logic [`RN_LANES-1:0] lane_mask_t;

    // Free-list occupancy, 0 up to the full depth
    typedef logic [`RN_CNT_W-1:0] fl_count_t;

endpackage

// ==== common/regmap_pkg.sv ====
`include "rename_params.svh"

// ========================================
// Register naming types
// ========================================

package regmap_pkg;

    // Architectural register number, x0 to x31
    typedef logic [`RN_ARCH_W-1:0] arch_reg_t;

    // Physical tag
    // Top bit clear means the register file entry of the same number
    // Top bit set means reorder-buffer slot tag minus 32
    typedef logic [`RN_TAG_W-1:0] phys_tag_t;

    // Reorder-buffer index, also the free-list payload
    typedef logic [`RN_ROB_W-1:0] rob_idx_t;

endpackage

// ==== common/rename_params.svh ====
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// Lanes renamed per cycle
`define RN_LANES     3

// Architectural register file
`define RN_ARCH_REGS 32
`define RN_ARCH_W    5

// Physical tag, top bit selects the reorder buffer
`define RN_TAG_W     6

// Reorder-buffer index and free-list ring
`define RN_ROB_W     5
`define RN_FL_DEPTH  32

// Occupancy counter must hold the full depth
`define RN_CNT_W     6

`endif
